//--- filelist.f
common/descriptor_pkg.sv
common/grad_stream_if.sv
common/bin_stream_if.sv
descriptor/patch_scanner.sv
descriptor/orientation_binner.sv
descriptor/histogram_accumulator.sv
descriptor/descriptor_top.sv
verification/gradient_memory.sv
verification/descriptor_tb.sv

//--- Makefile
# Verilator build and run for the descriptor testbench

VERILATOR ?= verilator
TOP       ?= descriptor_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- verification/descriptor_tb.sv
`timescale 1ns/1ps
`default_nettype none

module descriptor_tb;
  import descriptor_pkg::*;

  localparam int num_kp = 64;
  localparam int words_per_kp = (patch_size / sub_size) * (patch_size / sub_size);
  localparam int total_words = num_kp * words_per_kp;
  // about 20 cycles of slack per pixel under back-pressure
  localparam int max_cycles = num_kp * pix_per_kp * 20;
  localparam int quiet_limit = 50;

  logic clk = 1'b0;
  logic rst_in = 1'b1;
  logic kp_valid = 1'b0;
  logic kp_ready;
  logic [coord_w-1:0] kp_x = '0;
  logic [coord_w-1:0] kp_y = '0;
  logic kp_level = 1'b0;
  logic grad_rd;
  logic [grad_addr_w-1:0] grad_addr;
  logic signed [grad_w-1:0] grad_x;
  logic signed [grad_w-1:0] grad_y;
  logic desc_valid;
  logic desc_ready = 1'b0;
  logic [desc_w-1:0] desc_data;
  logic desc_last;

  logic [31:0] lfsr_state = 32'h7437;
  logic [coord_w-1:0] kp_xs [num_kp];
  logic [coord_w-1:0] kp_ys [num_kp];
  logic kp_lvls [num_kp];
  logic [desc_w-1:0] exp_words [$];
  bit exp_last [$];
  int kp_sent = 0;
  int words_seen = 0;
  int cycle_cnt = 0;
  int quiet_cycles = 0;

  descriptor_top dut (
    .clk        (clk),
    .rst_in     (rst_in),
    .kp_valid   (kp_valid),
    .kp_ready   (kp_ready),
    .kp_x       (kp_x),
    .kp_y       (kp_y),
    .kp_level   (kp_level),
    .grad_rd    (grad_rd),
    .grad_addr  (grad_addr),
    .grad_x     (grad_x),
    .grad_y     (grad_y),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .desc_data  (desc_data),
    .desc_last  (desc_last)
  );

  gradient_memory u_mem (
    .clk       (clk),
    .grad_rd   (grad_rd),
    .grad_addr (grad_addr),
    .grad_x    (grad_x),
    .grad_y    (grad_y)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  function automatic logic [coord_w-1:0] pick_edge(input logic [1:0] sel);
    case (sel)
      2'd0: return coord_w'(0);
      2'd1: return coord_w'(1);
      2'd2: return coord_w'(img_dim - 2);
      default: return coord_w'(img_dim - 1);
    endcase
  endfunction

  // patch origin is two pixels up-left, pushed back inside the image
  function automatic int origin_of(input int c);
    int o;
    o = c - patch_size / 2;
    if (o < 0) begin
      o = 0;
    end
    if (o > img_dim - patch_size) begin
      o = img_dim - patch_size;
    end
    return o;
  endfunction

  // orientation bin by quadrant and half, -1 when there is no gradient
  function automatic int bin_of(input int gx, input int gy);
    int q;
    int h;
    int ax;
    int ay;
    if (gx == 0 && gy == 0) begin
      return -1;
    end
    ax = (gx < 0) ? -gx : gx;
    ay = (gy < 0) ? -gy : gy;
    if (gx > 0 && gy >= 0) begin
      q = 0;
    end else if (gx <= 0 && gy > 0) begin
      q = 1;
    end else if (gx < 0 && gy <= 0) begin
      q = 2;
    end else begin
      q = 3;
    end
    if (q == 0 || q == 2) begin
      h = (ay > ax) ? 1 : 0;
    end else begin
      h = (ax > ay) ? 1 : 0;
    end
    return 2 * q + h;
  endfunction

  // four expected words per keypoint, subpatches TL, TR, BL, BR
  task automatic model_keypoint(input logic [coord_w-1:0] x, input logic [coord_w-1:0] y,
                                input logic level);
    int ox;
    int oy;
    int row;
    int col;
    int b;
    int counts [num_bins];
    logic [grad_addr_w-1:0] addr;
    logic [desc_w-1:0] word;
    ox = origin_of(int'(x));
    oy = origin_of(int'(y));
    for (int s = 0; s < words_per_kp; s++) begin
      word = '0;
      for (int k = 0; k < num_bins; k++) begin
        counts[k] = 0;
      end
      for (int p = 0; p < sub_size * sub_size; p++) begin
        row = oy + (s / 2) * sub_size + p / sub_size;
        col = ox + (s % 2) * sub_size + p % sub_size;
        addr = {level, coord_w'(row), coord_w'(col)};
        b = bin_of(int'(u_mem.gx_mem[addr]), int'(u_mem.gy_mem[addr]));
        // pixels without a gradient count nowhere
        if (b >= 0) begin
          counts[bin_w'(b)]++;
        end
      end
      for (int k = 0; k < num_bins; k++) begin
        word[k*count_w +: count_w] = count_w'(counts[k]);
      end
      exp_words.push_back(word);
      exp_last.push_back(s == words_per_kp - 1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("** FAIL **");
    $fatal(1, "%s", why);
  endtask

  task automatic check_word();
    logic [desc_w-1:0] want;
    bit want_last;
    assert (exp_words.size() > 0) begin
      want = exp_words.pop_front();
      want_last = exp_last.pop_front();
      assert (desc_data == want && desc_last == want_last) begin
        words_seen++;
      end else begin
        $display("Fail: time %0t word %0d got %h last %b, expected %h last %b",
                 $time, words_seen, desc_data, desc_last, want, want_last);
        abort_run("descriptor word mismatch");
      end
    end else begin
      $display("descriptor word %0d came out with no word expected", words_seen);
      abort_run("unexpected descriptor word");
    end
  endtask

  task automatic finish_run();
    if (exp_words.size() == 0 && kp_sent == num_kp) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("run ended with %0d words still expected and %0d keypoints sent",
               exp_words.size(), kp_sent);
      abort_run("descriptor words missing at end of run");
    end
  endtask

  initial begin
    for (int i = 0; i < num_kp; i++) begin
      if (i % 3 == 2) begin
        // same point on the other gradient plane
        kp_xs[i] = kp_xs[i-1];
        kp_ys[i] = kp_ys[i-1];
        kp_lvls[i] = !kp_lvls[i-1];
      end else if (i % 3 == 1) begin
        kp_xs[i] = pick_edge(2'(rand_bits(2)));
        kp_ys[i] = pick_edge(2'(rand_bits(2)));
        kp_lvls[i] = 1'(rand_bits(1));
      end else begin
        kp_xs[i] = coord_w'(rand_bits(coord_w));
        kp_ys[i] = coord_w'(rand_bits(coord_w));
        kp_lvls[i] = 1'(rand_bits(1));
      end
    end
    repeat (2) @(posedge clk);
    rst_in <= 1'b0;
    // idle state right after reset
    @(negedge clk);
    assert (kp_ready && !grad_rd && !desc_valid) else begin
      $display("Fail: time %0t after reset kp_ready %b grad_rd %b desc_valid %b",
               $time, kp_ready, grad_rd, desc_valid);
      abort_run("wrong state after reset");
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("timeout after %0d cycles, %0d of %0d descriptor words received",
               cycle_cnt, words_seen, total_words);
      abort_run("simulation ran out of cycles");
    end else if (!rst_in) begin
      if (kp_valid && kp_ready) begin
        model_keypoint(kp_x, kp_y, kp_level);
        kp_sent++;
      end
      // payload holds while valid waits for ready
      if (!kp_valid || kp_ready) begin
        if (kp_sent < num_kp && rand_bits(2) != 0) begin
          kp_valid <= 1'b1;
          kp_x <= kp_xs[kp_sent];
          kp_y <= kp_ys[kp_sent];
          kp_level <= kp_lvls[kp_sent];
        end else begin
          kp_valid <= 1'b0;
        end
      end
      desc_ready <= (rand_bits(2) != 0);
      if (desc_valid && desc_ready) begin
        check_word();
      end else if (words_seen == total_words) begin
        assert (!desc_valid) begin
          quiet_cycles++;
          if (quiet_cycles == quiet_limit) begin
            finish_run();
          end
        end else begin
          $display("desc_valid raised after all %0d words were received", total_words);
          abort_run("extra descriptor word");
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/gradient_memory.sv
`timescale 1ns/1ps
`default_nettype none

module gradient_memory (
  input  logic clk,
  input  logic grad_rd,
  input  logic [descriptor_pkg::grad_addr_w-1:0] grad_addr,
  output logic signed [descriptor_pkg::grad_w-1:0] grad_x,
  output logic signed [descriptor_pkg::grad_w-1:0] grad_y
);
  import descriptor_pkg::*;

  localparam int depth = 2 ** grad_addr_w;

  // two planes of 16x16 gradients, addressed as {level, y, x}
  logic signed [grad_w-1:0] gx_mem [depth];
  logic signed [grad_w-1:0] gy_mem [depth];
  logic signed [grad_w-1:0] rd_x = '0;
  logic signed [grad_w-1:0] rd_y = '0;
  logic rd_valid = 1'b0;
  logic [31:0] lfsr_state = 32'h7437;

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  initial begin
    for (int a = 0; a < depth; a++) begin
      // roughly one pixel in eight has no gradient at all
      if (rand_bits(3) == 0) begin
        gx_mem[a] = '0;
        gy_mem[a] = '0;
      end else begin
        gx_mem[a] = grad_w'(rand_bits(grad_w));
        gy_mem[a] = grad_w'(rand_bits(grad_w));
      end
    end
  end

  // data shows up the cycle after the read
  always @(posedge clk) begin
    rd_valid <= grad_rd;
    if (grad_rd) begin
      rd_x <= gx_mem[grad_addr];
      rd_y <= gy_mem[grad_addr];
    end
  end

  // data is good for that one cycle only, the bus carries it inverted afterwards
  assign grad_x = rd_valid ? rd_x : ~rd_x;
  assign grad_y = rd_valid ? rd_y : ~rd_y;

endmodule

`default_nettype wire

//--- descriptor/descriptor_top.sv
`timescale 1ns/1ps
`default_nettype none

module descriptor_top (
  input  logic clk,
  input  logic rst_in,

  // keypoint stream
  input  logic kp_valid,
  output logic kp_ready,
  input  logic [descriptor_pkg::coord_w-1:0] kp_x,
  input  logic [descriptor_pkg::coord_w-1:0] kp_y,
  input  logic kp_level,

  // external gradient memory, one cycle read latency
  output logic grad_rd,
  output logic [descriptor_pkg::grad_addr_w-1:0] grad_addr,
  input  logic signed [descriptor_pkg::grad_w-1:0] grad_x,
  input  logic signed [descriptor_pkg::grad_w-1:0] grad_y,

  // descriptor words, four per keypoint
  output logic desc_valid,
  input  logic desc_ready,
  output logic [descriptor_pkg::desc_w-1:0] desc_data,
  output logic desc_last
);

  grad_stream_if grad_s ();
  bin_stream_if bin_s ();

  patch_scanner u_scanner (
    .clk       (clk),
    .rst_in    (rst_in),
    .kp_valid  (kp_valid),
    .kp_ready  (kp_ready),
    .kp_x      (kp_x),
    .kp_y      (kp_y),
    .kp_level  (kp_level),
    .grad_rd   (grad_rd),
    .grad_addr (grad_addr),
    .grad_x    (grad_x),
    .grad_y    (grad_y),
    .out       (grad_s.src)
  );

  orientation_binner u_binner (
    .clk    (clk),
    .rst_in (rst_in),
    .in     (grad_s.snk),
    .out    (bin_s.src)
  );

  histogram_accumulator u_accum (
    .clk        (clk),
    .rst_in     (rst_in),
    .in         (bin_s.snk),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .desc_data  (desc_data),
    .desc_last  (desc_last)
  );

endmodule

`default_nettype wire

//--- descriptor/histogram_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module histogram_accumulator (
  input  logic clk,
  input  logic rst_in,
  bin_stream_if.snk in,
  output logic desc_valid,
  input  logic desc_ready,
  output logic [descriptor_pkg::desc_w-1:0] desc_data,
  output logic desc_last
);
  import descriptor_pkg::*;

  logic [count_w-1:0] counts [num_bins];
  logic [count_w-1:0] counts_next [num_bins];
  logic [desc_w-1:0] word_next;
  logic take;

  // stall only while a finished word sits unaccepted
  assign in.ready = !desc_valid || desc_ready;
  assign take = in.valid && in.ready;

  // counts with the current pixel folded in
  always_comb begin
    for (int i = 0; i < num_bins; i++) begin
      counts_next[i] = counts[i];
      if (in.has_bin && in.bin == bin_w'(i)) begin
        counts_next[i] = counts[i] + 1'b1;
      end
      word_next[i*count_w +: count_w] = counts_next[i];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_in) begin
      for (int i = 0; i < num_bins; i++) begin
        counts[i] <= '0;
      end
    end else if (take) begin
      // restart from zero for the next subpatch
      for (int i = 0; i < num_bins; i++) begin
        counts[i] <= in.sub_last ? '0 : counts_next[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_in) begin
      desc_valid <= 1'b0;
    end else if (take && in.sub_last) begin
      desc_valid <= 1'b1;
    end else if (desc_ready) begin
      desc_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take && in.sub_last) begin
      desc_data <= word_next;
      desc_last <= in.kp_last;
    end
  end

  // a subpatch has only four pixels
  for (genvar g = 0; g < num_bins; g++) begin : g_count_chk
    a_count_max: assert property (@(posedge clk) disable iff (rst_in)
      counts[g] <= count_w'(max_count));
  end

endmodule

`default_nettype wire

//--- descriptor/orientation_binner.sv
`timescale 1ns/1ps
`default_nettype none

module orientation_binner (
  input logic clk,
  input logic rst_in,
  grad_stream_if.snk in,
  bin_stream_if.src out
);
  import descriptor_pkg::*;

  logic [1:0] quad;
  logic half;
  logic nonzero;
  logic [grad_w-1:0] mag_x;
  logic [grad_w-1:0] mag_y;

  // one-entry stage, take a new sample when empty or draining
  assign in.ready = !out.valid || out.ready;

  // magnitude of -128 is 128, which still fits unsigned
  assign mag_x = in.gx[grad_w-1] ? grad_w'(-in.gx) : grad_w'(in.gx);
  assign mag_y = in.gy[grad_w-1] ? grad_w'(-in.gy) : grad_w'(in.gy);

  assign nonzero = (in.gx != 0) || (in.gy != 0);

  always_comb begin
    if (in.gx > 0 && in.gy >= 0) begin
      quad = 2'd0;
    end else if (in.gx <= 0 && in.gy > 0) begin
      quad = 2'd1;
    end else if (in.gx < 0 && in.gy <= 0) begin
      quad = 2'd2;
    end else begin
      quad = 2'd3;
    end
  end

  // odd quadrants compare the other way round
  assign half = quad[0] ? (mag_x > mag_y) : (mag_y > mag_x);

  always_ff @(posedge clk) begin
    if (rst_in) begin
      out.valid <= 1'b0;
    end else if (in.valid && in.ready) begin
      out.valid <= 1'b1;
    end else if (out.ready) begin
      out.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in.valid && in.ready) begin
      out.bin <= {quad, half};
      out.has_bin <= nonzero;
      out.sub_last <= in.sub_last;
      out.kp_last <= in.kp_last;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (rst_in)
    (out.valid && !out.ready) |=>
      (out.valid && $stable(out.bin) && $stable(out.has_bin) &&
       $stable(out.sub_last) && $stable(out.kp_last)));

endmodule

`default_nettype wire

//--- descriptor/patch_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module patch_scanner (
  input  logic clk,
  input  logic rst_in,
  input  logic kp_valid,
  output logic kp_ready,
  input  logic [descriptor_pkg::coord_w-1:0] kp_x,
  input  logic [descriptor_pkg::coord_w-1:0] kp_y,
  input  logic kp_level,
  output logic grad_rd,
  output logic [descriptor_pkg::grad_addr_w-1:0] grad_addr,
  input  logic signed [descriptor_pkg::grad_w-1:0] grad_x,
  input  logic signed [descriptor_pkg::grad_w-1:0] grad_y,
  grad_stream_if.src out
);
  import descriptor_pkg::*;

  logic busy;
  logic kp_take;
  logic [coord_w-1:0] org_x;
  logic [coord_w-1:0] org_y;
  logic lvl;
  logic [pix_w-1:0] pix_cnt;
  logic [pix_w-1:0] slot_idx;
  logic rd_pending;
  logic held;
  logic slot_full;
  logic signed [grad_w-1:0] hold_gx;
  logic signed [grad_w-1:0] hold_gy;
  logic [coord_w-1:0] row;
  logic [coord_w-1:0] col;

  // origin is coord - 2, kept inside 0..12
  function automatic logic [coord_w-1:0] clamp_origin(input logic [coord_w-1:0] c);
    if (c < coord_w'(half_patch)) begin
      return '0;
    end else if (c > coord_w'(max_origin + half_patch)) begin
      return coord_w'(max_origin);
    end
    return c - coord_w'(half_patch);
  endfunction

  assign kp_ready = !busy;
  assign kp_take = kp_valid && kp_ready;

  // slot holds either the sample returning now or one that stalled earlier
  assign slot_full = rd_pending || held;

  // read only if the slot is free on the next cycle
  assign grad_rd = busy && (!slot_full || out.ready);

  // cnt[3:2] picks the subpatch, cnt[1:0] the pixel inside it, row-major
  assign row = org_y + coord_w'({pix_cnt[3], pix_cnt[1]});
  assign col = org_x + coord_w'({pix_cnt[2], pix_cnt[0]});
  assign grad_addr = {lvl, row, col};

  assign out.valid = slot_full;
  assign out.gx = held ? hold_gx : grad_x;
  assign out.gy = held ? hold_gy : grad_y;
  assign out.sub_last = (slot_idx[1:0] == 2'b11);
  assign out.kp_last = &slot_idx;

  always_ff @(posedge clk) begin
    if (rst_in) begin
      busy <= 1'b0;
      pix_cnt <= '0;
      rd_pending <= 1'b0;
      held <= 1'b0;
    end else begin
      if (kp_take) begin
        busy <= 1'b1;
      end else if (grad_rd && (&pix_cnt)) begin
        busy <= 1'b0;
      end
      if (grad_rd) begin
        pix_cnt <= pix_cnt + 1'b1;
      end
      rd_pending <= grad_rd;
      // memory data lasts one cycle, so park it if the binner stalls
      if (rd_pending && !out.ready) begin
        held <= 1'b1;
      end else if (out.ready) begin
        held <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (kp_take) begin
      org_x <= clamp_origin(kp_x);
      org_y <= clamp_origin(kp_y);
      lvl <= kp_level;
    end
    if (grad_rd) begin
      slot_idx <= pix_cnt;
    end
    if (rd_pending && !out.ready) begin
      hold_gx <= grad_x;
      hold_gy <= grad_y;
    end
  end

  a_addr_in_patch: assert property (@(posedge clk) disable iff (rst_in)
    grad_rd |->
      (org_x <= coord_w'(max_origin)) && (org_y <= coord_w'(max_origin)) &&
      (grad_addr[coord_w-1:0] >= org_x) &&
      (grad_addr[coord_w-1:0] <= org_x + coord_w'(patch_size - 1)) &&
      (grad_addr[2*coord_w-1:coord_w] >= org_y) &&
      (grad_addr[2*coord_w-1:coord_w] <= org_y + coord_w'(patch_size - 1)));

endmodule

`default_nettype wire

//--- common/bin_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bin_stream_if;
  import descriptor_pkg::*;

  logic valid;
  logic ready;
  logic [bin_w-1:0] bin;
  // low when gx and gy are both zero
  logic has_bin;
  logic sub_last;
  logic kp_last;

  modport src (output valid, bin, has_bin, sub_last, kp_last, input ready);
  modport snk (input valid, bin, has_bin, sub_last, kp_last, output ready);

endinterface

`default_nettype wire

//--- common/grad_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface grad_stream_if;
  import descriptor_pkg::*;

  logic valid;
  logic ready;
  logic signed [grad_w-1:0] gx;
  logic signed [grad_w-1:0] gy;
  // fourth pixel of a subpatch
  logic sub_last;
  // sixteenth pixel of the keypoint
  logic kp_last;

  modport src (output valid, gx, gy, sub_last, kp_last, input ready);
  modport snk (input valid, gx, gy, sub_last, kp_last, output ready);

endinterface

`default_nettype wire

//--- common/descriptor_pkg.sv
`default_nettype none

package descriptor_pkg;

  // image geometry, one octave only
  localparam int img_dim = 16;
  localparam int coord_w = $clog2(img_dim);

  // patch around a keypoint, split into 2x2 subpatches
  localparam int patch_size = 4;
  localparam int sub_size = 2;
  localparam int half_patch = patch_size / 2;

  // highest legal patch origin on either axis
  localparam int max_origin = img_dim - patch_size;

  // pixel counter walks all 16 patch pixels
  localparam int pix_per_kp = patch_size * patch_size;
  localparam int pix_w = $clog2(pix_per_kp);

  // signed gradient samples
  localparam int grad_w = 8;

  // gradient memory address is {level, y, x}
  localparam int grad_addr_w = 1 + 2 * coord_w;

  // orientation histogram
  localparam int num_bins = 8;
  localparam int bin_w = $clog2(num_bins);

  // one count per bin, at most sub_size*sub_size = 4 hits
  localparam int max_count = sub_size * sub_size;
  localparam int count_w = $clog2(max_count + 1);

  // bin 0 in the low bits, higher bins above it
  localparam int desc_w = num_bins * count_w;

endpackage

`default_nettype wire
